/* sources.f */
+incdir+include
source/vec_pkg.sv
source/vec_uop_if.sv
source/vec_decoder.sv
source/inst_record.sv
source/convoy_ctrl.sv
source/dispatch_stage.sv
source/vec_top.sv
test/tb_vec_top.sv

/* include/tb_vec_ref.svh */
`ifndef TB_VEC_REF_SVH
`define TB_VEC_REF_SVH

//////////////////////////////////////////////////
// Expected decode of one IF/ID word, packed as
// {rs1_idx, rs2_idx, vs1, vs2, vd, uimm5, funct, permute, mask_en, alu_src,
//  dmr, dmw, reg_we, mem_reg, xout, mode_lsu}
function automatic logic [45:0] ref_decode(input logic [31:0] w);
	logic [4:0] a;      // Bits 19:15, vs1 or rs1 or immediate
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] vs1;
	logic [3:0] fn;
	logic [1:0] perm;
	logic [1:0] src;
	logic [1:0] lsu;
	logic       ld;
	logic       st;
	logic       we;
	a  = w[19:15];
	ld = (w[6:0] == vec_pkg::OP_VEC_LOAD);
	st = (w[6:0] == vec_pkg::OP_VEC_STORE);
	{rs1, rs2, vs1, fn, perm, src, lsu, we} =
		{15'd0, vec_pkg::FN_NONE, 2'd0, vec_pkg::SRC_VEC, vec_pkg::LSU_UNIT, 1'b0};
	if (w[6:0] == vec_pkg::OP_VEC_ARITH) begin
		rs1 = a;
		vs1 = a;        // Also the immediate
		case (w[31:26])
			vec_pkg::F6_VADD:     fn = vec_pkg::FN_ADD;
			vec_pkg::F6_VSUB:     fn = vec_pkg::FN_SUB;
			vec_pkg::F6_VAND:     fn = vec_pkg::FN_AND;
			vec_pkg::F6_VOR:      fn = vec_pkg::FN_OR;
			vec_pkg::F6_VXOR:     fn = vec_pkg::FN_XOR;
			vec_pkg::F6_VSLL:     fn = vec_pkg::FN_SLL;
			vec_pkg::F6_VSRL:     fn = vec_pkg::FN_SRL;
			vec_pkg::F6_VSLIDEDN: fn = vec_pkg::FN_SLIDEDN;
			vec_pkg::F6_VMVXS:    if (w[14:12] == vec_pkg::F3_OPMVV) fn = vec_pkg::FN_MVXS;
			default: ;
		endcase
		if (w[14:12] == vec_pkg::F3_OPIVX)
			src = vec_pkg::SRC_SCALAR;
		else if (w[14:12] == vec_pkg::F3_OPIVI)
			src = vec_pkg::SRC_IMM;
		if (fn == vec_pkg::FN_SLIDEDN)
			perm = a[1:0];    // Slide amount
		we = (fn != vec_pkg::FN_NONE) && (fn != vec_pkg::FN_MVXS);
	end else if (ld || st) begin
		rs1 = a;            // Base
		rs2 = w[24:20];     // Stride or index
		src = vec_pkg::SRC_SCALAR;
		case (w[27:26])
			2'b00:   lsu = vec_pkg::LSU_UNIT;
			2'b10:   lsu = vec_pkg::LSU_STRIDED;
			default: lsu = vec_pkg::LSU_INDEXED;
		endcase
		we = ld;
	end
	return {rs1, rs2, vs1, w[24:20], w[11:7], vs1, fn, perm, ~w[25], src,
		ld, st, we, ld, fn == vec_pkg::FN_MVXS, lsu};
endfunction

// Scalar register file contents, a fixed pattern of the index
function automatic logic [31:0] reg_pattern(input logic [4:0] idx);
	return (32'h9e37_79b9 * {27'd0, idx}) ^ {idx, 27'h2d2_d2d2};
endfunction

`endif

/* test/tb_vec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vec_top;

	`include "tb_vec_ref.svh"

	localparam logic [31:0] NOP   = 32'h0000_0013;  // addi x0, x0, 0
	localparam int          LIMIT = 200;             // Cycles per wait

	logic reset;                       // Clock
	logic clk;                         // Async reset
	logic branch_taken;
	logic [31:0] if_id;
	logic [31:0] rs1_data, rs2_data;
	logic freeze_vector_ops, exec_stall, exec_done;
	logic v_stall, freeze_x, freeze_v, freeze;
	logic [4:0] rs1_sel, rs2_sel;
	logic i_start, i_clear;
	logic [vec_pkg::IDX_W-1:0] i_id;
	logic [31:0] i_rs1, i_rs2;
	logic [4:0] i_vs1, i_vs2, i_vd, i_uimm5;
	logic [3:0] i_funct;
	logic [1:0] i_permute, i_alu_src, i_mode_lsu;
	logic i_mask_en, i_dmr, i_dmw, i_reg_we, i_mem_reg, i_xout;

	integer      seed;
	logic [31:0] rnd;
	logic [31:0] words [9];   // Words of the next convoy
	logic [48:0] exp_q [$];   // {i_id, expected decode}
	logic [48:0] head;
	logic        stall_rand;  // Random back-pressure on
	logic        stall_prev;  // exec_stall of the previous cycle
	int          n_issued;
	int          recorded;
	int          value_errs;
	int          proto_errs;
	int          timeouts;

	vec_top dut_i (.*, .Branch_Taken__EX_MEM(branch_taken), .Instruction__IF_ID(if_id));

	assign rs1_data = reg_pattern(rs1_sel);  // Register file without latency
	assign rs2_data = reg_pattern(rs2_sel);

	initial begin
		reset = 1'b0;
		forever #20 reset = ~reset;
	end

	//////////////////////////////////////////////////
	task automatic check(input logic [47:0] got, input logic [47:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			value_errs++;
		end
	endtask

	task automatic next_cycle();
		@(posedge reset);
		#2;
		rnd = $random(seed);
		exec_stall = stall_rand & rnd[0];
	endtask

	function automatic logic [31:0] make_arith(input int kind);
		logic [31:0] r;
		logic [5:0]  f6;
		logic [2:0]  f3;
		r = $random(seed);
		case (r[3:0])
			4'd0:    f6 = vec_pkg::F6_VADD;
			4'd1:    f6 = vec_pkg::F6_VSUB;
			4'd2:    f6 = vec_pkg::F6_VAND;
			4'd3:    f6 = vec_pkg::F6_VOR;
			4'd4:    f6 = vec_pkg::F6_VXOR;
			4'd5:    f6 = vec_pkg::F6_VSLL;
			4'd6:    f6 = vec_pkg::F6_VSRL;
			4'd7:    f6 = vec_pkg::F6_VSLIDEDN;
			4'd8:    f6 = vec_pkg::F6_VMVXS;   // Unknown unless OPMVV
			default: f6 = r[31:26];            // Mostly unknown encodings
		endcase
		case (kind)
			0:       f3 = vec_pkg::F3_OPIVV;
			1:       f3 = vec_pkg::F3_OPIVX;
			2:       f3 = vec_pkg::F3_OPIVI;
			default: begin
				f3 = vec_pkg::F3_OPMVV;            // vmv.x.s
				f6 = vec_pkg::F6_VMVXS;
			end
		endcase
		return {f6, r[25:15], f3, r[11:7], vec_pkg::OP_VEC_ARITH};
	endfunction

	function automatic logic [31:0] make_mem(input logic store, input logic [1:0] mop);
		logic [31:0] r;
		r = $random(seed);
		return {r[31:28], mop, r[25:12], r[11:7],
			store ? vec_pkg::OP_VEC_STORE : vec_pkg::OP_VEC_LOAD};
	endfunction

	//////////////////////////////////////////////////
	// Scoreboard samples the instruction port mid-cycle
	always @(negedge reset) begin
		if (i_start && stall_prev) begin
			$display("Issue at %0t although exec_stall was high", $time);
			proto_errs++;
		end
		if (i_start && exp_q.size() == 0) begin
			$display("Issue at %0t with no recorded instruction left", $time);
			proto_errs++;
		end else if (i_start) begin
			head = exp_q.pop_front();
			n_issued++;
			check(i_id, head[48:46], "i_id");
			check(i_clear, 0, "i_clear during issue");
			check(i_rs1, reg_pattern(head[45:41]), "i_rs1");
			check(i_rs2, reg_pattern(head[40:36]), "i_rs2");
			check({i_vs1, i_vs2, i_vd, i_uimm5, i_funct, i_permute, i_mask_en, i_alu_src,
				i_dmr, i_dmw, i_reg_we, i_mem_reg, i_xout, i_mode_lsu}, head[35:0], "fields");
		end
		stall_prev = exec_stall;
	end

	// Words one per cycle, then a scalar word; held words are not recorded
	task automatic send_convoy(input int n, input logic [8:0] hold);
		recorded = 0;
		for (int i = 0; i < n; i++) begin
			next_cycle();
			if_id = words[i];
			freeze_vector_ops = hold[i];
			if (!hold[i] && recorded < vec_pkg::N_LANES) begin
				exp_q.push_back({recorded[2:0], ref_decode(words[i])});
				recorded++;
			end
		end
		next_cycle();
		if_id = NOP;
		freeze_vector_ops = 1'b0;
		next_cycle();
		check(freeze_x, recorded < vec_pkg::N_LANES, "freeze_x");
		check(freeze_v, recorded == vec_pkg::N_LANES, "freeze_v");
		check(freeze, 1, "freeze");
		check(v_stall, 1, "v_stall");
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < LIMIT) begin
			check(v_stall, 1, "v_stall during issue");
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout at %0t, %0d entries never issued", $time, exp_q.size());
			timeouts++;
			exp_q.delete();
		end
	endtask

	// exec_done after a random latency
	task automatic release_convoy();
		int lat;
		rnd = $random(seed);
		lat = rnd[1:0];
		repeat (lat) begin
			check(v_stall, 1, "v_stall before exec_done");
			next_cycle();
		end
		exec_done = 1'b1;
		next_cycle();
		exec_done = 1'b0;
		check({v_stall, freeze_x, freeze_v, freeze, i_start}, 0, "stall and freeze after release");
		check(i_clear, 1, "i_clear after release");
	endtask

	task automatic run_convoy(input int n, input logic [8:0] hold);
		int start;
		start = n_issued;
		send_convoy(n, hold);
		wait_drained();
		release_convoy();
		check(n_issued - start, recorded, "issue count");
	endtask

	// Taken branch on the third word of a convoy and a fourth word one cycle later
	task automatic abort_convoy();
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			if_id = words[i];
			branch_taken = (i == 2);
		end
		next_cycle();
		if_id = NOP;
		repeat (4) begin           // No issue may follow
			check({v_stall, freeze}, 0, "stall and freeze after branch");
			next_cycle();
		end
	endtask

	// Taken branch just after the first issue of a convoy
	task automatic branch_after_issue();
		send_convoy(3, 9'd0);
		next_cycle();              // Entry 0 issues at this edge
		branch_taken = 1'b1;
		next_cycle();
		branch_taken = 1'b0;
		check({v_stall, freeze, i_clear}, 3'b001, "outputs after branch");
		exp_q.delete();            // Entries 1 and 2 never issue
		repeat (4) begin
			check({v_stall, freeze, i_start}, 0, "outputs after branch");
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////
	initial begin
		seed = 32'h815e_a312;
		clk = 1'b1;
		{branch_taken, freeze_vector_ops, exec_stall, exec_done} = '0;
		if_id = NOP;
		{stall_rand, stall_prev} = '0;
		{n_issued, value_errs, proto_errs, timeouts} = '0;
		repeat (8) @(posedge reset);
		#2;
		clk = 1'b0;
		check({i_start, v_stall, freeze_x, freeze_v, freeze}, 0, "outputs after reset");
		check(i_clear, 1, "i_clear after reset");

		for (int c = 0; c < 4; c++) begin  // Arithmetic convoys of random length
			for (int i = 0; i < 9; i++)
				words[i] = make_arith(i % 4);
			rnd = $random(seed);
			run_convoy(rnd[2:0] + 1, 9'd0);
		end
		for (int i = 0; i < 8; i++)        // Loads and stores with every mop
			words[i] = make_mem(i[0], i[2:1]);
		run_convoy(8, 9'd0);
		for (int i = 0; i < 9; i++)
			words[i] = make_arith(i % 4);
		run_convoy(9, 9'd0);               // Overflow
		run_convoy(3, 9'd0);               // Scalar interruption

		stall_rand = 1'b1;
		for (int c = 0; c < 3; c++) begin
			for (int i = 0; i < 9; i++)
				words[i] = (i % 3 == 0) ? make_mem(i[1], i[2:1]) : make_arith(i % 4);
			run_convoy(7, 9'b0_0010_0100);   // Holds on words 2 and 5
		end
		stall_rand = 1'b0;

		abort_convoy();
		branch_after_issue();
		run_convoy(4, 9'd0);               // Normal after abort

		$display("Errors: %0d value, %0d protocol, %0d timeout",
			value_errs, proto_errs, timeouts);
		if (value_errs + proto_errs + timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* source/vec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_top (
	input  logic                      reset,                // Clock
	input  logic                      clk,                  // Async reset, active high
	input  logic                      Branch_Taken__EX_MEM,
	input  logic [31:0]               Instruction__IF_ID,
	input  logic [31:0]               rs1_data,
	input  logic [31:0]               rs2_data,
	input  logic                      freeze_vector_ops,
	input  logic                      exec_stall,
	input  logic                      exec_done,
	output logic                      v_stall,
	output logic                      freeze_x,
	output logic                      freeze_v,
	output logic                      freeze,               // Freeze scalar pipeline
	output logic [4:0]                rs1_sel,
	output logic [4:0]                rs2_sel,
	output logic                      i_start,
	output logic                      i_clear,
	output logic [vec_pkg::IDX_W-1:0] i_id,
	output logic [31:0]               i_rs1,
	output logic [31:0]               i_rs2,
	output logic [4:0]                i_vs1,
	output logic [4:0]                i_vs2,
	output logic [4:0]                i_vd,
	output logic [4:0]                i_uimm5,
	output logic [3:0]                i_funct,
	output logic [1:0]                i_permute,
	output logic                      i_mask_en,
	output logic [1:0]                i_alu_src,
	output logic                      i_dmr,
	output logic                      i_dmw,
	output logic                      i_reg_we,
	output logic                      i_mem_reg,
	output logic                      i_xout,
	output logic [1:0]                i_mode_lsu
);

	logic                      is_vec;
	logic                      rec_we;
	logic                      issue;
	logic                      flush;
	logic [vec_pkg::IDX_W-1:0] wr_idx;
	logic [vec_pkg::IDX_W-1:0] rd_idx;

	vec_uop_if dec_uop ();   // Decoder to record
	vec_uop_if rec_uop ();   // Record to dispatch

	assign freeze = freeze_x | freeze_v;

	//////////////////////////////////////////////////
	vec_decoder u_dec (.inst(Instruction__IF_ID), .is_vec(is_vec), .uop(dec_uop));

	inst_record u_rec (
		.reset(reset), .clk(clk), .rec_we(rec_we), .wr_idx(wr_idx), .rd_idx(rd_idx),
		.wr(dec_uop), .rd(rec_uop), .rs1_sel(rs1_sel), .rs2_sel(rs2_sel)
	);

	convoy_ctrl u_ctrl (
		.reset(reset), .clk(clk), .is_vec(is_vec), .branch_taken(Branch_Taken__EX_MEM),
		.freeze_vector_ops(freeze_vector_ops), .exec_stall(exec_stall),
		.exec_done(exec_done), .rec_we(rec_we), .wr_idx(wr_idx), .rd_idx(rd_idx),
		.issue(issue), .flush(flush), .v_stall(v_stall), .freeze_x(freeze_x),
		.freeze_v(freeze_v)
	);

	dispatch_stage u_disp (
		.reset(reset), .clk(clk), .issue(issue), .flush(flush), .rd_idx(rd_idx),
		.uop(rec_uop), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.i_start(i_start), .i_clear(i_clear), .i_id(i_id), .i_rs1(i_rs1),
		.i_rs2(i_rs2), .i_vs1(i_vs1), .i_vs2(i_vs2), .i_vd(i_vd), .i_uimm5(i_uimm5),
		.i_funct(i_funct), .i_permute(i_permute), .i_mask_en(i_mask_en),
		.i_alu_src(i_alu_src), .i_dmr(i_dmr), .i_dmw(i_dmw), .i_reg_we(i_reg_we),
		.i_mem_reg(i_mem_reg), .i_xout(i_xout), .i_mode_lsu(i_mode_lsu)
	);

endmodule

`default_nettype wire

/* source/dispatch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage (
	input  logic                      reset,     // Clock
	input  logic                      clk,       // Async reset, active high
	input  logic                      issue,
	input  logic                      flush,
	input  logic [vec_pkg::IDX_W-1:0] rd_idx,
	vec_uop_if.dst                    uop,       // Entry at rd_idx
	input  logic [31:0]               rs1_data,  // Scalar operands
	input  logic [31:0]               rs2_data,
	output logic                      i_start,   // One pulse per issued entry
	output logic                      i_clear,   // Convoy released
	output logic [vec_pkg::IDX_W-1:0] i_id,
	output logic [31:0]               i_rs1,
	output logic [31:0]               i_rs2,
	output logic [4:0]                i_vs1,
	output logic [4:0]                i_vs2,
	output logic [4:0]                i_vd,
	output logic [4:0]                i_uimm5,
	output logic [3:0]                i_funct,
	output logic [1:0]                i_permute,
	output logic                      i_mask_en,
	output logic [1:0]                i_alu_src,
	output logic                      i_dmr,
	output logic                      i_dmw,
	output logic                      i_reg_we,
	output logic                      i_mem_reg,
	output logic                      i_xout,
	output logic [1:0]                i_mode_lsu
);

	//////////////////////////////////////////////////
	// Instruction port to the execution unit
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			i_start <= 1'b0;
			i_clear <= 1'b1;
			{i_id, i_rs1, i_rs2} <= '0;
			{i_vs1, i_vs2, i_vd, i_uimm5, i_funct, i_permute, i_mask_en, i_alu_src,
				i_dmr, i_dmw, i_reg_we, i_mem_reg, i_xout, i_mode_lsu} <= '0;
		end else if (flush) begin
			i_start <= 1'b0;
			i_clear <= 1'b1;      // Unit drops the whole convoy
			{i_id, i_rs1, i_rs2} <= '0;
			{i_vs1, i_vs2, i_vd, i_uimm5, i_funct, i_permute, i_mask_en, i_alu_src,
				i_dmr, i_dmw, i_reg_we, i_mem_reg, i_xout, i_mode_lsu} <= '0;
		end else if (issue) begin
			i_start <= 1'b1;
			i_clear <= 1'b0;
			i_id    <= rd_idx;
			i_rs1   <= rs1_data;  // Read through rs1_sel this cycle
			i_rs2   <= rs2_data;
			{i_vs1, i_vs2, i_vd, i_uimm5, i_funct, i_permute, i_mask_en, i_alu_src,
				i_dmr, i_dmw, i_reg_we, i_mem_reg, i_xout, i_mode_lsu} <=
				{uop.vs1, uop.vs2, uop.vd, uop.uimm5, uop.funct, uop.permute,
				uop.mask_en, uop.alu_src, uop.dmr, uop.dmw, uop.reg_we,
				uop.mem_reg, uop.xout, uop.mode_lsu};
		end else begin
			i_start <= 1'b0;      // Fields hold under stall
		end
	end

endmodule

`default_nettype wire

/* source/convoy_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module convoy_ctrl (
	input  logic                      reset,             // Clock
	input  logic                      clk,               // Async reset, active high
	input  logic                      is_vec,            // IF/ID word is vector
	input  logic                      branch_taken,      // EX/MEM
	input  logic                      freeze_vector_ops, // Hold, word ignored
	input  logic                      exec_stall,        // Back-pressure
	input  logic                      exec_done,
	output logic                      rec_we,
	output logic [vec_pkg::IDX_W-1:0] wr_idx,
	output logic [vec_pkg::IDX_W-1:0] rd_idx,
	output logic                      issue,
	output logic                      flush,
	output logic                      v_stall,           // Stall fetch
	output logic                      freeze_x,          // Ended by a scalar word
	output logic                      freeze_v           // Ended by a full record
);

	logic [1:0]                state;
	logic [vec_pkg::IDX_W:0]   cnt;       // Entries recorded, up to N_LANES
	logic [vec_pkg::IDX_W-1:0] ptr;       // Next entry to issue
	logic                      br_d;      // Branch of the previous cycle
	logic                      abort;
	logic                      take;      // Word of this cycle counts
	logic                      last_rec;
	logic                      last_iss;

	assign abort    = branch_taken | br_d;
	assign take     = ~freeze_vector_ops & ~abort;
	assign last_rec = (cnt == vec_pkg::N_LANES - 1);
	assign last_iss = ({1'b0, ptr} == cnt - 1'b1);

	//////////////////////////////////////////////////
	// Record and dispatch strobes
	assign rec_we = take & is_vec &
		(state == vec_pkg::ST_IDLE || state == vec_pkg::ST_COLLECT);
	assign wr_idx = cnt[vec_pkg::IDX_W-1:0];  // Zero while idle
	assign rd_idx = ptr;
	assign issue  = (state == vec_pkg::ST_ISSUE) & ~exec_stall & ~abort;

	// Release on done, abort on a branch from any busy state
	assign flush = (state != vec_pkg::ST_IDLE) &
		(abort | (state == vec_pkg::ST_DRAIN & exec_done));

	//////////////////////////////////////////////////
	// Convoy FSM
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state    <= vec_pkg::ST_IDLE;
			cnt      <= '0;
			ptr      <= '0;
			br_d     <= 1'b0;
			v_stall  <= 1'b0;
			freeze_x <= 1'b0;
			freeze_v <= 1'b0;
		end else begin
			br_d <= branch_taken;
			if (flush) begin
				state    <= vec_pkg::ST_IDLE;  // Record emptied
				cnt      <= '0;
				ptr      <= '0;
				v_stall  <= 1'b0;
				freeze_x <= 1'b0;
				freeze_v <= 1'b0;
			end else begin
				case (state)
					vec_pkg::ST_IDLE: begin
						if (rec_we) begin         // Entry 0 written now
							state   <= vec_pkg::ST_COLLECT;
							cnt     <= cnt + 1'b1;
							v_stall <= 1'b1;
						end
					end
					vec_pkg::ST_COLLECT: begin
						if (take && !is_vec) begin
							freeze_x <= 1'b1;     // Scalar word ends the convoy
							state    <= vec_pkg::ST_ISSUE;
						end else if (take) begin
							cnt <= cnt + 1'b1;
							if (last_rec) begin
								freeze_v <= 1'b1; // Record full
								state    <= vec_pkg::ST_ISSUE;
							end
						end
					end
					vec_pkg::ST_ISSUE: begin
						if (issue) begin
							ptr <= ptr + 1'b1;
							if (last_iss)
								state <= vec_pkg::ST_DRAIN;
						end
					end
					default: ;  // Drain waits for exec_done through flush
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/inst_record.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_record (
	input  logic                      reset,   // Clock
	input  logic                      clk,     // Async reset, active high
	input  logic                      rec_we,
	input  logic [vec_pkg::IDX_W-1:0] wr_idx,
	input  logic [vec_pkg::IDX_W-1:0] rd_idx,
	vec_uop_if.dst                    wr,      // From the decoder
	vec_uop_if.src                    rd,      // Entry at rd_idx
	output logic [4:0]                rs1_sel, // To the scalar register file
	output logic [4:0]                rs2_sel
);

	logic [vec_pkg::UOP_W-1:0]   mem [vec_pkg::N_LANES];
	logic [vec_pkg::N_LANES-1:0] valid;         // Entries of the current convoy
	logic [vec_pkg::UOP_W-1:0]   wdata;
	logic [vec_pkg::UOP_W-1:0]   rdata;

	assign wdata = {wr.vs1, wr.vs2, wr.vd, wr.rs1_idx, wr.rs2_idx, wr.uimm5,
		wr.funct, wr.permute, wr.mask_en, wr.alu_src, wr.dmr, wr.dmw,
		wr.reg_we, wr.mem_reg, wr.xout, wr.mode_lsu};

	// Storage
	always_ff @(posedge reset) begin
		if (rec_we)
			mem[wr_idx] <= wdata;
	end

	// Entry 0 starts a new convoy, older entries drop out
	always_ff @(posedge reset or posedge clk) begin
		if (clk)
			valid <= '0;
		else if (rec_we)
			valid <= ((wr_idx == '0) ? '0 : valid) | (vec_pkg::N_LANES'(1) << wr_idx);
	end

	//////////////////////////////////////////////////
	// Read port, stale entries read as zero
	assign rdata = valid[rd_idx] ? mem[rd_idx] : '0;

	assign {rd.vs1, rd.vs2, rd.vd, rd.rs1_idx, rd.rs2_idx, rd.uimm5,
		rd.funct, rd.permute, rd.mask_en, rd.alu_src, rd.dmr, rd.dmw,
		rd.reg_we, rd.mem_reg, rd.xout, rd.mode_lsu} = rdata;

	assign rs1_sel = rd.rs1_idx;  // Operand data comes back the same cycle
	assign rs2_sel = rd.rs2_idx;

endmodule

`default_nettype wire

/* source/vec_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module vec_decoder (
	input  logic [31:0] inst,    // IF/ID word
	output logic        is_vec,  // One of the three vector opcodes
	vec_uop_if.src      uop
);

	vec_pkg::vec_inst_u w;
	logic               is_arith;
	logic               is_load;
	logic               is_store;
	logic [3:0]         fn;      // funct6 mapped to internal code

	assign w        = inst;
	assign is_arith = (w.arith.opcode == vec_pkg::OP_VEC_ARITH);
	assign is_load  = (w.mem.opcode == vec_pkg::OP_VEC_LOAD);
	assign is_store = (w.mem.opcode == vec_pkg::OP_VEC_STORE);
	assign is_vec   = is_arith | is_load | is_store;

	//////////////////////////////////////////////////
	// Operation lookup
	always_comb begin
		case (w.arith.funct6)
			vec_pkg::F6_VADD:     fn = vec_pkg::FN_ADD;
			vec_pkg::F6_VSUB:     fn = vec_pkg::FN_SUB;
			vec_pkg::F6_VAND:     fn = vec_pkg::FN_AND;
			vec_pkg::F6_VOR:      fn = vec_pkg::FN_OR;
			vec_pkg::F6_VXOR:     fn = vec_pkg::FN_XOR;
			vec_pkg::F6_VSLL:     fn = vec_pkg::FN_SLL;
			vec_pkg::F6_VSRL:     fn = vec_pkg::FN_SRL;
			vec_pkg::F6_VSLIDEDN: fn = vec_pkg::FN_SLIDEDN;
			vec_pkg::F6_VMVXS:    fn = (w.arith.funct3 == vec_pkg::F3_OPMVV) ?
			                           vec_pkg::FN_MVXS : vec_pkg::FN_NONE;
			default:              fn = vec_pkg::FN_NONE;
		endcase
	end

	// Operand source
	always_comb begin
		if (is_load | is_store)
			uop.alu_src = vec_pkg::SRC_SCALAR;  // Memory ops add a scalar base
		else if (is_arith && w.arith.funct3 == vec_pkg::F3_OPIVX)
			uop.alu_src = vec_pkg::SRC_SCALAR;
		else if (is_arith && w.arith.funct3 == vec_pkg::F3_OPIVI)
			uop.alu_src = vec_pkg::SRC_IMM;
		else
			uop.alu_src = vec_pkg::SRC_VEC;   // OPIVV, OPMVV
	end

	// Addressing mode from mop
	always_comb begin
		if (!(is_load | is_store))
			uop.mode_lsu = vec_pkg::LSU_UNIT;
		else if (w.mem.mop == 2'b00)
			uop.mode_lsu = vec_pkg::LSU_UNIT;
		else if (w.mem.mop == 2'b10)
			uop.mode_lsu = vec_pkg::LSU_STRIDED;
		else
			uop.mode_lsu = vec_pkg::LSU_INDEXED;  // Ordered and unordered
	end

	//////////////////////////////////////////////////
	// Register fields
	assign uop.vs1     = is_arith ? w.arith.vs1 : 5'd0;
	assign uop.vs2     = w.arith.vs2;              // Same bits as rs2
	assign uop.vd      = w.arith.vd;
	assign uop.rs1_idx = w.mem.rs1;                // Same bits as vs1
	assign uop.rs2_idx = is_arith ? 5'd0 : w.mem.rs2;
	assign uop.uimm5   = is_arith ? w.arith.vs1 : 5'd0;
	assign uop.mask_en = ~w.arith.vm;

	// Control fields
	assign uop.funct   = is_arith ? fn : vec_pkg::FN_NONE;
	assign uop.permute = (is_arith && fn == vec_pkg::FN_SLIDEDN) ? w.arith.vs1[1:0] : 2'd0;
	assign uop.dmr     = is_load;
	assign uop.dmw     = is_store;
	assign uop.mem_reg = is_load;                  // Load data goes to the vector file
	assign uop.xout    = is_arith && fn == vec_pkg::FN_MVXS;
	assign uop.reg_we  = is_load |
		(is_arith && fn != vec_pkg::FN_NONE && fn != vec_pkg::FN_MVXS);

endmodule

`default_nettype wire

/* source/vec_uop_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Decoded vector instruction, one entry wide
interface vec_uop_if;
	logic [4:0] vs1;
	logic [4:0] vs2;
	logic [4:0] vd;
	logic [4:0] rs1_idx;    // Scalar register indices
	logic [4:0] rs2_idx;
	logic [4:0] uimm5;
	logic [3:0] funct;
	logic [1:0] permute;    // Slide amount
	logic       mask_en;
	logic [1:0] alu_src;
	logic       dmr;        // Vector memory read
	logic       dmw;        // Vector memory write
	logic       reg_we;
	logic       mem_reg;    // Writeback from memory
	logic       xout;       // Scalar result
	logic [1:0] mode_lsu;

	modport src (output vs1, vs2, vd, rs1_idx, rs2_idx, uimm5, funct, permute,
		mask_en, alu_src, dmr, dmw, reg_we, mem_reg, xout, mode_lsu);
	modport dst (input vs1, vs2, vd, rs1_idx, rs2_idx, uimm5, funct, permute,
		mask_en, alu_src, dmr, dmw, reg_we, mem_reg, xout, mode_lsu);
endinterface

`default_nettype wire

/* source/vec_pkg.sv */
`default_nettype none

package vec_pkg;

	//////////////////////////////////////////////////
	// Record sizing
	localparam int N_LANES = 8;                   // Entries per convoy
	localparam int IDX_W   = 3;                   // Record index width
	localparam int UOP_W   = 46;                  // Packed width of one decoded entry

	// Major opcodes of the vector extension
	localparam logic [6:0] OP_VEC_LOAD  = 7'b0000111;
	localparam logic [6:0] OP_VEC_STORE = 7'b0100111;
	localparam logic [6:0] OP_VEC_ARITH = 7'b1010111;

	// funct3 operand categories
	localparam logic [2:0] F3_OPIVV = 3'b000;     // vector-vector
	localparam logic [2:0] F3_OPMVV = 3'b010;     // vector-vector, mask/move group
	localparam logic [2:0] F3_OPIVI = 3'b011;     // vector-immediate
	localparam logic [2:0] F3_OPIVX = 3'b100;     // vector-scalar

	// Internal operation codes seen by the execution unit
	localparam logic [3:0] FN_ADD     = 4'd0;
	localparam logic [3:0] FN_SUB     = 4'd1;
	localparam logic [3:0] FN_AND     = 4'd2;
	localparam logic [3:0] FN_OR      = 4'd3;
	localparam logic [3:0] FN_XOR     = 4'd4;
	localparam logic [3:0] FN_SLL     = 4'd5;
	localparam logic [3:0] FN_SRL     = 4'd6;
	localparam logic [3:0] FN_MVXS    = 4'd7;
	localparam logic [3:0] FN_SLIDEDN = 4'd8;
	localparam logic [3:0] FN_NONE    = 4'd15;  // Unknown funct6

	// funct6 encodings
	localparam logic [5:0] F6_VADD     = 6'b000000;
	localparam logic [5:0] F6_VSUB     = 6'b000010;
	localparam logic [5:0] F6_VAND     = 6'b001001;
	localparam logic [5:0] F6_VOR      = 6'b001010;
	localparam logic [5:0] F6_VXOR     = 6'b001011;
	localparam logic [5:0] F6_VSLL     = 6'b100101;
	localparam logic [5:0] F6_VSRL     = 6'b101000;
	localparam logic [5:0] F6_VMVXS    = 6'b010000;  // OPMVV only
	localparam logic [5:0] F6_VSLIDEDN = 6'b001111;

	// ALU operand source
	localparam logic [1:0] SRC_VEC    = 2'b00;
	localparam logic [1:0] SRC_SCALAR = 2'b01;
	localparam logic [1:0] SRC_IMM    = 2'b11;

	// Load-store addressing mode
	localparam logic [1:0] LSU_UNIT    = 2'b00;
	localparam logic [1:0] LSU_STRIDED = 2'b01;
	localparam logic [1:0] LSU_INDEXED = 2'b11;

	// Convoy FSM states
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_COLLECT = 2'd1;
	localparam logic [1:0] ST_ISSUE   = 2'd2;
	localparam logic [1:0] ST_DRAIN   = 2'd3;

	//////////////////////////////////////////////////
	// One instruction word, arithmetic and memory layouts
	typedef union packed {
		struct packed {
			logic [5:0] funct6;
			logic       vm;       // 0 = masked
			logic [4:0] vs2;
			logic [4:0] vs1;      // Also uimm5 / rs1
			logic [2:0] funct3;
			logic [4:0] vd;
			logic [6:0] opcode;
		} arith;
		struct packed {
			logic [2:0] nf;
			logic       mew;
			logic [1:0] mop;      // Addressing mode
			logic       vm;
			logic [4:0] rs2;      // Stride or index register
			logic [4:0] rs1;      // Base address register
			logic [2:0] width;
			logic [4:0] vd;       // vs3 for stores
			logic [6:0] opcode;
		} mem;
	} vec_inst_u;

endpackage

`default_nettype wire
